//--- mem_stage.f
source/lsu_pkg.sv
source/store_align.sv
source/load_extend.sv
source/data_ram.sv
source/lsu_csr.sv
source/mem_stage.sv
verification/tb_clock_gen.sv
verification/mem_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the mem_stage testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_stage_tb -f mem_stage.f -o mem_stage_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/mem_stage_sim > sim.log 2>&1 || echo "Simulator returned a non-zero status"
cat sim.log

grep -q "Something failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Run ended without a pass line"; exit 1; }
echo "Simulation passed"

//--- source/data_ram.sv
module data_ram (
    input  logic                       clk,
    input  logic [3:0]                 we_i,
    input  logic [lsu_pkg::RAM_AW-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0]   wdata_i,
    output logic [lsu_pkg::XLEN-1:0]   rdata_o
);

    localparam int DEPTH = 2 ** lsu_pkg::RAM_AW;

    logic [lsu_pkg::XLEN-1:0] mem [DEPTH];

    ////////////////////
    // Write and read port
    ////////////////////

    // One address serves both directions. The read returns the word as it was
    // before this edge, so a store is seen by a load on the following edge.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we_i[i]) begin
                mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];   // Lane i only.
            end
        end
        rdata_o <= mem[addr_i];                               // Old contents.
    end

endmodule

//--- source/load_extend.sv
module load_extend (
    input  logic [2:0]               funct3_i,
    input  logic [1:0]               addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0] word_i,
    output logic [lsu_pkg::XLEN-1:0] data_o
);

    lsu_pkg::mem_word_u word_v;
    logic [7:0]         sel_byte;
    logic [15:0]        sel_half;

    ////////////////////
    // Lane select
    ////////////////////

    assign word_v   = word_i;
    assign sel_byte = word_v.bytes[addr_lo_i];            // Byte at the offset.
    assign sel_half = word_v.halves[addr_lo_i[1]];        // Halfword at bit 1.

    ////////////////////
    // Extension
    ////////////////////

    always_comb begin
        case (funct3_i)
            lsu_pkg::F3_B: begin
                data_o = {{(lsu_pkg::XLEN-8){sel_byte[7]}}, sel_byte};
            end
            lsu_pkg::F3_BU: begin
                data_o = {{(lsu_pkg::XLEN-8){1'b0}}, sel_byte};
            end
            lsu_pkg::F3_H: begin
                data_o = {{(lsu_pkg::XLEN-16){sel_half[15]}}, sel_half};
            end
            lsu_pkg::F3_HU: begin
                data_o = {{(lsu_pkg::XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                data_o = word_i;                          // LW passes through.
            end
        endcase
    end

endmodule

//--- source/lsu_csr.sv
module lsu_csr (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic [lsu_pkg::APB_AW-1:0] paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [lsu_pkg::XLEN-1:0]   pwdata_i,
    input  logic                       load_evt_i,
    input  logic                       store_evt_i,
    input  logic                       misal_evt_i,
    output logic [lsu_pkg::XLEN-1:0]   prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    output logic                       en_o,
    output logic                       fault_en_o
);

    logic                           access;
    logic                           wr_access;
    logic                           hit_ctrl;
    logic                           mapped;
    logic [2:0]                     hit_cnt;     // Misal, store, load.
    logic [2:0]                     clr;
    logic [2:0]                     evt;
    logic [1:0]                     ctrl_q;
    logic [2:0][lsu_pkg::XLEN-1:0]  cnt_q;

    ////////////////////
    // APB decode
    ////////////////////

    assign access    = psel_i && penable_i;
    assign wr_access = access && pwrite_i;

    assign hit_ctrl   = (paddr_i == lsu_pkg::REG_CTRL);
    assign hit_cnt[0] = (paddr_i == lsu_pkg::REG_LOAD_CNT);
    assign hit_cnt[1] = (paddr_i == lsu_pkg::REG_STORE_CNT);
    assign hit_cnt[2] = (paddr_i == lsu_pkg::REG_MISAL_CNT);
    assign mapped     = hit_ctrl || (hit_cnt != 3'b000);

    assign pready_o  = 1'b1;                       // No wait states.
    assign pslverr_o = access && !mapped;

    assign clr = hit_cnt & {3{wr_access}};
    assign evt = {misal_evt_i, store_evt_i, load_evt_i};

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            case (paddr_i)
                lsu_pkg::REG_CTRL:      prdata_o = {{(lsu_pkg::XLEN-2){1'b0}}, ctrl_q};
                lsu_pkg::REG_LOAD_CNT:  prdata_o = cnt_q[0];
                lsu_pkg::REG_STORE_CNT: prdata_o = cnt_q[1];
                lsu_pkg::REG_MISAL_CNT: prdata_o = cnt_q[2];
                default:                prdata_o = '0;
            endcase
        end
    end

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= 2'b00;                       // Datapath off after reset.
            cnt_q  <= '0;
        end else begin
            if (wr_access && hit_ctrl) begin
                ctrl_q[lsu_pkg::CTRL_EN_BIT]       <= pwdata_i[lsu_pkg::CTRL_EN_BIT];
                ctrl_q[lsu_pkg::CTRL_FAULT_EN_BIT] <= pwdata_i[lsu_pkg::CTRL_FAULT_EN_BIT];
            end
            for (int i = 0; i < 3; i++) begin
                if (clr[i]) begin
                    cnt_q[i] <= '0;                // Clear wins over a same-edge event.
                end else if (evt[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign en_o       = ctrl_q[lsu_pkg::CTRL_EN_BIT];
    assign fault_en_o = ctrl_q[lsu_pkg::CTRL_FAULT_EN_BIT];

    // Access phase only ever follows a selected setup phase
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (!arst_n_i) penable_i |-> psel_i
    ) else $error("lsu_csr: penable without psel");

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

    ////////////////////
    // Datapath sizes
    ////////////////////

    localparam int XLEN   = 32;                  // Data word width.
    localparam int RAM_AW = 8;                   // Word address bits, 256 words.

    ////////////////////
    // RV32I funct3
    ////////////////////

    localparam logic [2:0] F3_B  = 3'b000;       // LB and SB.
    localparam logic [2:0] F3_H  = 3'b001;       // LH and SH.
    localparam logic [2:0] F3_W  = 3'b010;       // LW and SW.
    localparam logic [2:0] F3_BU = 3'b100;       // LBU only.
    localparam logic [2:0] F3_HU = 3'b101;       // LHU only.

    ////////////////////
    // APB register map
    ////////////////////

    localparam int APB_AW = 4;

    localparam logic [APB_AW-1:0] REG_CTRL      = 4'h0;
    localparam logic [APB_AW-1:0] REG_LOAD_CNT  = 4'h4;
    localparam logic [APB_AW-1:0] REG_STORE_CNT = 4'h8;
    localparam logic [APB_AW-1:0] REG_MISAL_CNT = 4'hC;

    // Control register fields
    localparam int CTRL_EN_BIT       = 0;        // Gates every request.
    localparam int CTRL_FAULT_EN_BIT = 1;        // Misaligned access gives a fault response.

    ////////////////////
    // Read word views
    ////////////////////

    // The same 32 bits seen as byte lanes or as halfword lanes.
    typedef union packed {
        logic [3:0][7:0]  bytes;                 // Lane 0 is the lowest address.
        logic [1:0][15:0] halves;                // Half 1 sits at address bit 1 set.
    } mem_word_u;

endpackage

//--- source/mem_stage.sv
module mem_stage (
    input  logic                       clk,
    input  logic                       arst_n_i,
    // Request from execute
    input  logic                       req_valid_i,
    input  logic                       req_we_i,
    input  logic [2:0]                 req_funct3_i,
    input  logic [lsu_pkg::RAM_AW+1:0] req_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]   req_wdata_i,
    // Response to write-back
    output logic                       rsp_valid_o,
    output logic [lsu_pkg::XLEN-1:0]   rsp_rdata_o,
    output logic                       rsp_fault_o,
    // APB slave
    input  logic [lsu_pkg::APB_AW-1:0] paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [lsu_pkg::XLEN-1:0]   pwdata_i,
    output logic [lsu_pkg::XLEN-1:0]   prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);

    logic                     en;
    logic                     fault_en;
    logic                     acc;
    logic                     misal;
    logic                     load_evt;
    logic                     store_evt;
    logic                     misal_evt;
    logic [lsu_pkg::XLEN-1:0] st_data;
    logic [3:0]               st_mask;
    logic [3:0]               ram_we;
    logic [lsu_pkg::XLEN-1:0] ram_rdata;
    logic [lsu_pkg::XLEN-1:0] ld_data;
    logic                     ld_pend_q;
    logic                     fault_q;
    logic [2:0]               ld_funct3_q;
    logic [1:0]               ld_addr_lo_q;

    ////////////////////
    // Request accept
    ////////////////////

    assign acc       = req_valid_i && en;
    assign load_evt  = acc && !req_we_i && !misal;
    assign store_evt = acc && req_we_i && !misal;
    assign misal_evt = acc && misal;
    assign ram_we    = store_evt ? st_mask : 4'b0000;

    // Loads pass through here too, only for the alignment check
    store_align store_align_i (
        .funct3_i     (req_funct3_i),
        .addr_lo_i    (req_addr_i[1:0]),
        .data_i       (req_wdata_i),
        .data_o       (st_data),
        .wmask_o      (st_mask),
        .misaligned_o (misal)
    );

    data_ram data_ram_i (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (req_addr_i[lsu_pkg::RAM_AW+1:2]),
        .wdata_i (st_data),
        .rdata_o (ram_rdata)
    );

    ////////////////////
    // Response stage
    ////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ld_pend_q <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            ld_pend_q <= load_evt;
            fault_q   <= misal_evt && fault_en;   // Silent drop when faults are off.
        end
    end

    always_ff @(posedge clk) begin
        if (load_evt) begin
            ld_funct3_q  <= req_funct3_i;
            ld_addr_lo_q <= req_addr_i[1:0];
        end
    end

    load_extend load_extend_i (
        .funct3_i  (ld_funct3_q),
        .addr_lo_i (ld_addr_lo_q),
        .word_i    (ram_rdata),
        .data_o    (ld_data)
    );

    assign rsp_valid_o = ld_pend_q || fault_q;
    assign rsp_fault_o = fault_q;
    assign rsp_rdata_o = ld_pend_q ? ld_data : '0;

    lsu_csr lsu_csr_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .load_evt_i  (load_evt),
        .store_evt_i (store_evt),
        .misal_evt_i (misal_evt),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .en_o        (en),
        .fault_en_o  (fault_en)
    );

    // Stores come only as byte, halfword or word
    store_width_legal: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (acc && req_we_i) |-> (req_funct3_i == lsu_pkg::F3_B ||
                               req_funct3_i == lsu_pkg::F3_H ||
                               req_funct3_i == lsu_pkg::F3_W)
    ) else $error("mem_stage: store with a load-only funct3");

endmodule

//--- source/store_align.sv
module store_align (
    input  logic [2:0]               funct3_i,
    input  logic [1:0]               addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0] data_i,
    output logic [lsu_pkg::XLEN-1:0] data_o,
    output logic [3:0]               wmask_o,
    output logic                     misaligned_o
);

    ////////////////////
    // Lane steering
    ////////////////////

    always_comb begin
        data_o       = data_i;
        wmask_o      = 4'b0000;
        misaligned_o = 1'b0;

        case (funct3_i)
            lsu_pkg::F3_B, lsu_pkg::F3_BU: begin
                data_o  = data_i << {addr_lo_i, 3'b000};  // Byte to its lane.
                wmask_o = 4'b0001 << addr_lo_i;
            end
            lsu_pkg::F3_H, lsu_pkg::F3_HU: begin
                if (addr_lo_i[0]) begin
                    misaligned_o = 1'b1;
                end else if (addr_lo_i[1]) begin
                    data_o  = data_i << 16;                // Upper halfword.
                    wmask_o = 4'b1100;
                end else begin
                    wmask_o = 4'b0011;
                end
            end
            lsu_pkg::F3_W: begin
                if (addr_lo_i != 2'b00) begin
                    misaligned_o = 1'b1;
                end else begin
                    wmask_o = 4'b1111;
                end
            end
            default: begin
                wmask_o = 4'b0000;                         // Unknown width writes nothing.
            end
        endcase
    end

endmodule

//--- verification/mem_stage_tb.sv
module mem_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RSP_TIMEOUT  = 8;                 // Cycles allowed for an expected response.
    localparam int QUIET_CYCLES = 4;                 // Cycles that must stay silent.
    localparam logic [3:0] REG_UNMAPPED = 4'hE;
    localparam logic [9:0] SUB_BASE     = 10'h040;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    logic        req_we;
    logic [2:0]  req_funct3;
    logic [9:0]  req_addr;
    logic [31:0] req_wdata;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        rsp_fault;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] ref_mem [256];                      // Mirror of the data RAM.
    logic [15:0] lfsr_state = 16'd15;
    int          errors     = 0;
    int          checks     = 0;
    int          n_loads    = 0;
    int          n_stores   = 0;
    int          n_misal    = 0;

    tb_clock_gen clk_gen_i (.clk_o(clk), .arst_n_o(arst_n));

    mem_stage dut_i (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .req_we_i     (req_we),
        .req_funct3_i (req_funct3),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .rsp_valid_o  (rsp_valid),
        .rsp_rdata_o  (rsp_rdata),
        .rsp_fault_o  (rsp_fault),
        .paddr_i      (paddr),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};  // One step per bit.
        end
        return value;
    endfunction

    function automatic logic [31:0] expected_load(input logic [2:0] funct3,
                                                  input logic [1:0] off, input logic [31:0] word);
        lsu_pkg::mem_word_u w;
        w = word;
        case (funct3)
            lsu_pkg::F3_B:  return {{24{w.bytes[off][7]}}, w.bytes[off]};
            lsu_pkg::F3_BU: return {24'h0, w.bytes[off]};
            lsu_pkg::F3_H:  return {{16{w.halves[off[1]][15]}}, w.halves[off[1]]};
            lsu_pkg::F3_HU: return {16'h0, w.halves[off[1]]};
            default:        return word;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int cycles;
        @(posedge clk);
        psel    <= 1'b1;                             // Setup phase.
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;                             // Access phase.
        cycles = 0;
        @(negedge clk);
        while (!pready && cycles < RSP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready) begin
            $display("ERROR at %0t ns: APB slave never raised pready", $time);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic send_request(input logic we, input logic [2:0] funct3,
                                input logic [9:0] addr, input logic [31:0] data);
        @(posedge clk);
        req_valid  <= 1'b1;
        req_we     <= we;
        req_funct3 <= funct3;
        req_addr   <= addr;
        req_wdata  <= data;
        @(posedge clk);
        req_valid  <= 1'b0;                          // Taken on this edge.
    endtask

    task automatic wait_response(input int limit, output logic seen, output int cycles,
                                 output logic [31:0] data, output logic fault);
        seen   = 1'b0;
        cycles = 0;
        data   = '0;
        fault  = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (rsp_valid) begin
                seen  = 1'b1;
                data  = rsp_rdata;
                fault = rsp_fault;
            end
        end
    endtask

    task automatic expect_response(input logic fault_exp, input logic [31:0] data_exp);
        logic        seen;
        int          cycles;
        logic [31:0] data;
        logic        fault;
        wait_response(RSP_TIMEOUT, seen, cycles, data, fault);
        if (!seen) begin
            $display("ERROR at %0t ns: no response within %0d cycles", $time, RSP_TIMEOUT);
            errors++;
        end else begin
            check_value("response latency", 32'd1, 32'(cycles));
            check_value("rsp_fault_o", 32'(fault_exp), 32'(fault));
            check_value("rsp_rdata_o", data_exp, data);
        end
    endtask

    task automatic expect_silence(input string what);
        logic        seen;
        int          cycles;
        logic [31:0] data;
        logic        fault;
        wait_response(QUIET_CYCLES, seen, cycles, data, fault);
        check_value(what, 32'h0, 32'(seen));
    endtask

    task automatic do_store(input logic [2:0] funct3, input logic [9:0] addr,
                            input logic [31:0] data);
        lsu_pkg::mem_word_u w;
        w = ref_mem[addr[9:2]];
        case (funct3)
            lsu_pkg::F3_B: w.bytes[addr[1:0]] = data[7:0];
            lsu_pkg::F3_H: w.halves[addr[1]]  = data[15:0];
            default:       w = data;
        endcase
        send_request(1'b1, funct3, addr, data);
        ref_mem[addr[9:2]] = w;
        n_stores++;
    endtask

    task automatic do_load(input logic [2:0] funct3, input logic [9:0] addr);
        send_request(1'b0, funct3, addr, random_bits(32));
        n_loads++;
        expect_response(1'b0, expected_load(funct3, addr[1:0], ref_mem[addr[9:2]]));
    endtask

    task automatic misaligned_access(input logic we, input logic [2:0] funct3,
                                     input logic [9:0] addr, input logic fault_on);
        send_request(we, funct3, addr, random_bits(32));
        n_misal++;
        if (fault_on) begin
            expect_response(1'b1, 32'h0);
        end else begin
            expect_silence("rsp_valid_o on silent misaligned access");
        end
        do_load(lsu_pkg::F3_W, {addr[9:2], 2'b00});  // Word must be unchanged.
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_state();
        logic [31:0] rd;
        logic        err;
        apb_read(lsu_pkg::REG_CTRL, rd, err);
        check_value("ctrl after reset", 32'h0, rd);
        send_request(1'b0, lsu_pkg::F3_W, 10'h0, 32'h0);
        expect_silence("rsp_valid_o while disabled");
        apb_read(lsu_pkg::REG_LOAD_CNT, rd, err);
        check_value("load count while disabled", 32'h0, rd);
    endtask

    task automatic test_word_stores();
        logic [9:0] addr;
        logic       err;
        apb_write(lsu_pkg::REG_CTRL, 32'h1, err);
        for (int i = 0; i < 8; i++) begin
            addr = 10'(random_bits(8) << 2);
            do_store(lsu_pkg::F3_W, addr, random_bits(32));
            do_load(lsu_pkg::F3_W, addr);
        end
    endtask

    task automatic test_sub_word();
        do_store(lsu_pkg::F3_W, SUB_BASE, random_bits(32));
        for (int off = 0; off < 4; off++) begin
            do_store(lsu_pkg::F3_B, SUB_BASE + 10'(off), random_bits(32));
        end
        do_load(lsu_pkg::F3_W, SUB_BASE);
        do_store(lsu_pkg::F3_H, SUB_BASE + 10'd2, 32'h1234_8001);  // Negative upper half.
        do_store(lsu_pkg::F3_H, SUB_BASE, random_bits(32));
        do_load(lsu_pkg::F3_W, SUB_BASE);
        for (int off = 0; off < 4; off++) begin
            do_load(lsu_pkg::F3_B, SUB_BASE + 10'(off));
            do_load(lsu_pkg::F3_BU, SUB_BASE + 10'(off));
            if (off % 2 == 0) begin
                do_load(lsu_pkg::F3_H, SUB_BASE + 10'(off));
                do_load(lsu_pkg::F3_HU, SUB_BASE + 10'(off));
            end
        end
    endtask

    task automatic test_misaligned();
        logic err;
        for (int f = 0; f < 2; f++) begin
            apb_write(lsu_pkg::REG_CTRL, f[0] ? 32'h3 : 32'h1, err);
            for (int off = 1; off < 4; off++) begin
                misaligned_access(1'b1, lsu_pkg::F3_W, SUB_BASE + 10'(off), f[0]);
                misaligned_access(1'b0, lsu_pkg::F3_W, SUB_BASE + 10'(off), f[0]);
                if (off != 2) begin
                    misaligned_access(1'b1, lsu_pkg::F3_H, SUB_BASE + 10'(off), f[0]);
                    misaligned_access(1'b0, lsu_pkg::F3_HU, SUB_BASE + 10'(off), f[0]);
                end
            end
        end
    endtask

    task automatic test_counters();
        logic [31:0] rd;
        logic        err;
        apb_read(lsu_pkg::REG_LOAD_CNT, rd, err);
        check_value("load count", 32'(n_loads), rd);
        apb_read(lsu_pkg::REG_STORE_CNT, rd, err);
        check_value("store count", 32'(n_stores), rd);
        apb_read(lsu_pkg::REG_MISAL_CNT, rd, err);
        check_value("misaligned count", 32'(n_misal), rd);
        check_value("pslverr_o on mapped read", 32'h0, 32'(err));
        for (int i = 1; i < 4; i++) begin
            apb_write(4'(4 * i), 32'hFFFF_FFFF, err);
            apb_read(4'(4 * i), rd, err);
            check_value("counter after clear", 32'h0, rd);
        end
        apb_write(REG_UNMAPPED, 32'h0, err);
        check_value("pslverr_o on unmapped write", 32'h1, 32'(err));
        apb_read(REG_UNMAPPED, rd, err);
        check_value("pslverr_o on unmapped read", 32'h1, 32'(err));
        apb_read(lsu_pkg::REG_CTRL, rd, err);
        check_value("ctrl after unmapped write", 32'h3, rd);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int cycles;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_funct3 = 3'b000;
        req_addr   = '0;
        req_wdata  = '0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        cycles     = 0;
        while (arst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("ERROR at %0t ns: reset was never released", $time);
            errors++;
        end
        test_reset_state();
        test_word_stores();
        test_sub_word();
        test_misaligned();
        test_counters();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 20;        // 40 ns clock.
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;                    // Released on a rising edge.
    end

endmodule
